/* dig_game_pkg.sv */
// Game-side types for the digger core
// Grid coordinates, directions, keycodes, BCD score and move items
package dig_game_pkg;

    // ------------------------------------------------------------------------
    // Grid geometry
    // ------------------------------------------------------------------------
    localparam int COORD_W = 6;                 // Up to 64 tiles per axis

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } tile_pos_t;

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_UP,
        DIR_LEFT,
        DIR_DOWN,
        DIR_RIGHT
    } dir_e;

    // ------------------------------------------------------------------------
    // Keyboard usage codes
    // ------------------------------------------------------------------------
    typedef logic [7:0] keycode_t;

    localparam keycode_t KEY_W = 8'h1A;
    localparam keycode_t KEY_A = 8'h04;
    localparam keycode_t KEY_S = 8'h16;
    localparam keycode_t KEY_D = 8'h07;

    // Score and lives
    typedef logic [3:0] bcd_digit_t;

    typedef struct packed {
        bcd_digit_t thousands;
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t ones;
    } score_bcd_t;

    typedef logic [1:0] lives_t;

    // One tile change, motion to map
    typedef struct packed {
        logic      valid;
        tile_pos_t pos;
    } move_item_t;

endpackage

/* apb_pkg.sv */
// APB bus types and register map
// Request and response structs, address enum
package apb_pkg;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    // Master to slave
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // Byte addresses of the register block
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_KEYCODE = 4'd0,                     // RW, last key from host
        REG_HIT     = 4'd4,                     // WO, bit 0 reports a death
        REG_POS     = 4'd8,                     // RO, digger tile
        REG_SCORE   = 4'd12                     // RO, BCD score and lives
    } reg_addr_e;

endpackage

/* apb_regs.sv */
// APB slave register block
// Keycode register, hit pulse and status read mux
`timescale 1ns/1ps

module apb_regs (
    input  logic                   Clk,
    input  logic                   rst,
    input  apb_pkg::apb_req_t      apb_req,
    output apb_pkg::apb_rsp_t      apb_rsp,
    input  dig_game_pkg::tile_pos_t  pos,
    input  dig_game_pkg::score_bcd_t score,
    input  dig_game_pkg::lives_t     lives,
    output dig_game_pkg::keycode_t   keycode,
    output logic                   hit
);
    import apb_pkg::*;
    import dig_game_pkg::*;

    logic                  access;              // Second cycle of a transfer
    logic                  addr_ok;
    logic                  wr_en;
    logic [APB_DATA_W-1:0] rd_data;

    assign access = apb_req.psel & apb_req.penable;

    // ------------------------------------------------------------------------
    // Address decode and read mux
    // ------------------------------------------------------------------------
    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (reg_addr_e'(apb_req.paddr))
            REG_KEYCODE: begin
                rd_data[7:0] = keycode;
            end
            REG_HIT: begin
                rd_data = '0;                   // Write only
            end
            REG_POS: begin
                rd_data[COORD_W-1:0]  = pos.x;
                rd_data[8 +: COORD_W] = pos.y;
            end
            REG_SCORE: begin
                rd_data[15:0]  = score;
                rd_data[17:16] = lives;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    assign wr_en = access & apb_req.pwrite & addr_ok;

    // Zero wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~addr_ok;
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            keycode <= '0;
            hit     <= 1'b0;
        end else begin
            if (wr_en && reg_addr_e'(apb_req.paddr) == REG_KEYCODE) begin
                keycode <= apb_req.pwdata[7:0];
            end
            // Single cycle strobe per accepted write
            hit <= wr_en && (reg_addr_e'(apb_req.paddr) == REG_HIT) && apb_req.pwdata[0];
        end
    end

endmodule

/* dug_motion.sv */
// Digger motion on the tile grid
// Keycode to direction, bounded step per frame, move item output
`timescale 1ns/1ps

module dug_motion #(
    parameter int GRID_W  = 32,
    parameter int GRID_H  = 24,
    parameter int START_X = 5,
    parameter int START_Y = 5
) (
    input  logic                      Clk,
    input  logic                      rst,
    input  logic                      frame_tick,
    input  logic                      restart,
    input  dig_game_pkg::keycode_t    keycode,
    output dig_game_pkg::tile_pos_t   pos,
    output dig_game_pkg::move_item_t  move
);
    import dig_game_pkg::*;

    dir_e      dir;
    tile_pos_t next_pos;
    logic      step_ok;                         // Step stays on the grid
    logic      move_valid;

    // Only WASD steer the digger
    always_comb begin
        case (keycode)
            KEY_W:   dir = DIR_UP;
            KEY_A:   dir = DIR_LEFT;
            KEY_S:   dir = DIR_DOWN;
            KEY_D:   dir = DIR_RIGHT;
            default: dir = DIR_NONE;
        endcase
    end

    always_comb begin
        next_pos = pos;
        step_ok  = 1'b0;
        case (dir)
            DIR_UP: begin
                step_ok    = (pos.y != '0);
                next_pos.y = pos.y - 1'b1;
            end
            DIR_LEFT: begin
                step_ok    = (pos.x != '0);
                next_pos.x = pos.x - 1'b1;
            end
            DIR_DOWN: begin
                step_ok    = (pos.y != coord_t'(GRID_H - 1));
                next_pos.y = pos.y + 1'b1;
            end
            DIR_RIGHT: begin
                step_ok    = (pos.x != coord_t'(GRID_W - 1));
                next_pos.x = pos.x + 1'b1;
            end
            default: step_ok = 1'b0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst || restart) begin
            pos.x      <= coord_t'(START_X);
            pos.y      <= coord_t'(START_Y);
            move_valid <= 1'b0;
        end else if (frame_tick && step_ok) begin
            pos        <= next_pos;
            move_valid <= 1'b1;                 // New tile for the map
        end else begin
            move_valid <= 1'b0;
        end
    end

    assign move.valid = move_valid;
    assign move.pos   = pos;

endmodule

/* tunnel_map.sv */
// Tunnel map of dug tiles
// One bit per tile, first-entry detect, full clear on restart
`timescale 1ns/1ps

module tunnel_map #(
    parameter int GRID_W = 32,
    parameter int GRID_H = 24
) (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     restart,
    input  dig_game_pkg::move_item_t move,
    output logic                     new_dig
);
    import dig_game_pkg::*;

    logic [GRID_W-1:0] dug [GRID_H];            // Row words, bit per column
    logic [GRID_W-1:0] row_word;
    logic [GRID_W-1:0] col_mask;                // One-hot column of the move
    logic              tile_dug;

    // Select the addressed row and column
    always_comb begin
        row_word = '0;
        col_mask = '0;
        for (int r = 0; r < GRID_H; r++) begin
            if (move.pos.y == coord_t'(r)) row_word = dug[r];
        end
        for (int c = 0; c < GRID_W; c++) begin
            if (move.pos.x == coord_t'(c)) col_mask[c] = 1'b1;
        end
        tile_dug = |(row_word & col_mask);
    end

    always_ff @(posedge Clk) begin
        if (rst || restart) begin
            for (int r = 0; r < GRID_H; r++) begin
                dug[r] <= '0;
            end
            new_dig <= 1'b0;                    // Drops an item caught in restart
        end else if (move.valid) begin
            for (int r = 0; r < GRID_H; r++) begin
                if (move.pos.y == coord_t'(r)) dug[r] <= dug[r] | col_mask;
            end
            new_dig <= ~tile_dug;
        end else begin
            new_dig <= 1'b0;
        end
    end

endmodule

/* score_lives.sv */
// Score and lives keeper
// Four digit BCD dig count, life counter, game restart strobe
`timescale 1ns/1ps

module score_lives #(
    parameter int LIVES_INIT = 3
) (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     new_dig,
    input  logic                     hit,
    output dig_game_pkg::score_bcd_t score,
    output dig_game_pkg::lives_t     lives,
    output logic                     restart
);
    import dig_game_pkg::*;

    score_bcd_t score_inc;
    logic       last_life;

    // ------------------------------------------------------------------------
    // BCD increment with ripple carry, 9999 wraps to 0000
    // ------------------------------------------------------------------------
    always_comb begin
        score_inc = score;
        if (score.ones != 4'd9) begin
            score_inc.ones = score.ones + 1'b1;
        end else begin
            score_inc.ones = 4'd0;
            if (score.tens != 4'd9) begin
                score_inc.tens = score.tens + 1'b1;
            end else begin
                score_inc.tens = 4'd0;
                if (score.hundreds != 4'd9) begin
                    score_inc.hundreds = score.hundreds + 1'b1;
                end else begin
                    score_inc.hundreds  = 4'd0;
                    score_inc.thousands = (score.thousands != 4'd9) ?
                                          score.thousands + 1'b1 : 4'd0;
                end
            end
        end
    end

    assign last_life = (lives == lives_t'(1));

    always_ff @(posedge Clk) begin
        if (rst) begin
            score   <= '0;
            lives   <= lives_t'(LIVES_INIT);
            restart <= 1'b0;
        end else begin
            restart <= hit && last_life;
            if (hit && last_life) begin
                // Game over, start a fresh round
                score <= '0;
                lives <= lives_t'(LIVES_INIT);
            end else begin
                if (hit) lives <= lives - 1'b1;
                if (new_dig && !restart) score <= score_inc;   // Stale digs ignored
            end
        end
    end

endmodule

/* dig_game_top.sv */
// Digger game-state core top level
// APB registers, motion, tunnel map and score keeper
`timescale 1ns/1ps

module dig_game_top #(
    parameter int GRID_W     = 32,
    parameter int GRID_H     = 24,
    parameter int START_X    = 5,
    parameter int START_Y    = 5,
    parameter int LIVES_INIT = 3
) (
    input  logic              Clk,
    input  logic              rst,
    input  logic              frame_tick,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp
);
    import dig_game_pkg::*;

    keycode_t   keycode;
    logic       hit;
    tile_pos_t  pos;
    move_item_t move;
    logic       new_dig;
    score_bcd_t score;
    lives_t     lives;
    logic       restart;                        // End of game, one cycle

    apb_regs u_apb_regs (
        .Clk     (Clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pos     (pos),
        .score   (score),
        .lives   (lives),
        .keycode (keycode),
        .hit     (hit)
    );

    dug_motion #(
        .GRID_W  (GRID_W),
        .GRID_H  (GRID_H),
        .START_X (START_X),
        .START_Y (START_Y)
    ) u_dug_motion (
        .Clk        (Clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .restart    (restart),
        .keycode    (keycode),
        .pos        (pos),
        .move       (move)
    );

    tunnel_map #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_tunnel_map (
        .Clk     (Clk),
        .rst     (rst),
        .restart (restart),
        .move    (move),
        .new_dig (new_dig)
    );

    score_lives #(
        .LIVES_INIT (LIVES_INIT)
    ) u_score_lives (
        .Clk     (Clk),
        .rst     (rst),
        .new_dig (new_dig),
        .hit     (hit),
        .score   (score),
        .lives   (lives),
        .restart (restart)
    );

endmodule

/* dig_game_assertions.sv */
// Bound checks on the digger core
// APB handshake, hit and restart strobes, dig pulses
`timescale 1ns/1ps

module dig_game_assertions #(
    parameter int START_X = 5,
    parameter int START_Y = 5
) (
    input logic                     Clk,
    input logic                     rst,
    input apb_pkg::apb_req_t        apb_req,
    input apb_pkg::apb_rsp_t        apb_rsp,
    input logic                     hit,
    input logic                     restart,
    input logic                     new_dig,
    input dig_game_pkg::tile_pos_t  pos,
    input dig_game_pkg::move_item_t move
);
    import apb_pkg::*;
    import dig_game_pkg::*;

    int fails;                                      // Read by the testbench at the end

    initial fails = 0;

    // Every access completes at once, error flag only on unmapped addresses
    a_pready: assert property (@(posedge Clk) disable iff (rst)
        apb_req.psel && apb_req.penable |->
            apb_rsp.pready &&
            (apb_rsp.pslverr ==
             !(apb_req.paddr inside {REG_KEYCODE, REG_HIT, REG_POS, REG_SCORE})))
        else begin fails++; $error("pready or pslverr wrong in an APB access cycle"); end

    a_hit_pulse: assert property (@(posedge Clk) disable iff (rst)
        hit |=> !hit)
        else begin fails++; $error("hit held longer than one cycle"); end

    // Digger back on its start tile right after a restart
    a_restart_pos: assert property (@(posedge Clk) disable iff (rst)
        restart |=> (pos.x == coord_t'(START_X) && pos.y == coord_t'(START_Y)))
        else begin fails++; $error("pos not at start after restart"); end

    a_dig_source: assert property (@(posedge Clk) disable iff (rst)
        new_dig |-> $past(move.valid))
        else begin fails++; $error("new_dig without a preceding move"); end

endmodule

bind dig_game_top dig_game_assertions #(
    .START_X (START_X),
    .START_Y (START_Y)
) u_assertions (
    .Clk     (Clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .hit     (hit),
    .restart (restart),
    .new_dig (new_dig),
    .pos     (pos),
    .move    (move)
);

/* tb_dig_game.sv */
// Directed testbench for the digger game-state core
// Reference model, APB and frame tasks, xorshift random walk
`timescale 1ns/1ps

module tb_dig_game;
    import apb_pkg::*;
    import dig_game_pkg::*;

    localparam int GRID_W     = 32;
    localparam int GRID_H     = 24;
    localparam int START_X    = 5;
    localparam int START_Y    = 5;
    localparam int LIVES_INIT = 3;
    localparam keycode_t KEY_SPACE = 8'h2C;          // Unmapped key
    localparam logic [31:0] SEED = 32'h72849fe9;
    localparam int WALK_FRAMES = 200;
    // About 1400 transfers and frames of at most 5 cycles each, doubled
    localparam int OPS_EST     = 1400;
    localparam int CYCLE_LIMIT = 2 * 5 * OPS_EST;

    logic     Clk;
    logic     rst;
    logic     frame_tick;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // Reference model state
    tile_pos_t m_pos;
    bit        m_dug [GRID_H][GRID_W];
    int        m_score;
    int        m_lives;
    keycode_t  m_key;

    int          errors;
    int          checks;
    int          tests;
    int          cycles;
    logic [31:0] rng;

    dig_game_top dut (
        .Clk        (Clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    initial Clk = 1'b0;
    always #20 Clk = ~Clk;

    initial cycles = 0;
    always @(posedge Clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Decimal count to four BCD digits
    function automatic score_bcd_t to_bcd(input int value);
        score_bcd_t s;
        s.thousands = bcd_digit_t'((value / 1000) % 10);
        s.hundreds  = bcd_digit_t'((value / 100) % 10);
        s.tens      = bcd_digit_t'((value / 10) % 10);
        s.ones      = bcd_digit_t'(value % 10);
        return s;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic model_restart();
        m_pos.x = coord_t'(START_X);
        m_pos.y = coord_t'(START_Y);
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) m_dug[r][c] = 1'b0;
        end
        m_score = 0;
        m_lives = LIVES_INIT;
    endtask

    task automatic model_frame(input keycode_t key);
        int x;
        int y;
        bit step;
        x    = int'(m_pos.x);
        y    = int'(m_pos.y);
        step = 1'b1;
        case (key)
            KEY_W:   y = y - 1;
            KEY_A:   x = x - 1;
            KEY_S:   y = y + 1;
            KEY_D:   x = x + 1;
            default: step = 1'b0;
        endcase
        if (step && x >= 0 && x < GRID_W && y >= 0 && y < GRID_H) begin
            m_pos.x = coord_t'(x);
            m_pos.y = coord_t'(y);
            if (!m_dug[y][x]) begin                 // First entry scores
                m_dug[y][x] = 1'b1;
                m_score     = (m_score + 1) % 10000;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_pos(input tile_pos_t exp, input tile_pos_t got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected (%0d,%0d) got (%0d,%0d)",
                     $time, what, exp.x, exp.y, got.x, got.y);
        end
    endtask

    task automatic check_score(input score_bcd_t exp, input score_bcd_t got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_lives(input lives_t exp, input lives_t got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_word(input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus and frame tasks, all start and end 2 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge Clk);
        #2;
    endtask

    task automatic settle();
        repeat (3) next_cycle();
    endtask

    task automatic apb_xfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata);
        logic exp_err;
        exp_err = !(addr == REG_KEYCODE || addr == REG_HIT ||
                    addr == REG_POS || addr == REG_SCORE);
        apb_req.psel    = 1'b1;                     // Setup cycle
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        next_cycle();
        apb_req.penable = 1'b1;
        @(negedge Clk);                             // Mid access cycle
        rdata = apb_rsp.prdata;
        check_word(APB_DATA_W'(1'b1), APB_DATA_W'(apb_rsp.pready), "pready");
        check_word(APB_DATA_W'(exp_err), APB_DATA_W'(apb_rsp.pslverr), "pslverr");
        next_cycle();
        apb_req = '0;
        settle();
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] d);
        logic [APB_DATA_W-1:0] unused;
        apb_xfer(1'b1, addr, d, unused);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] d);
        apb_xfer(1'b0, addr, '0, d);
    endtask

    task automatic tick();
        frame_tick = 1'b1;
        next_cycle();
        frame_tick = 1'b0;
        settle();
        model_frame(m_key);
    endtask

    task automatic set_key(input keycode_t key);
        apb_write(REG_KEYCODE, APB_DATA_W'(key));
        m_key = key;
    endtask

    task automatic send_hit();
        apb_write(REG_HIT, 32'h1);
        if (m_lives == 1) model_restart();          // Last life ends the game
        else m_lives--;
    endtask

    task automatic verify_pos();
        logic [APB_DATA_W-1:0] d;
        tile_pos_t             p;
        apb_read(REG_POS, d);
        p.x = d[5:0];
        p.y = d[13:8];
        check_pos(m_pos, p, "pos");
    endtask

    task automatic verify_score();
        logic [APB_DATA_W-1:0] d;
        apb_read(REG_SCORE, d);
        check_score(to_bcd(m_score), d[15:0], "score");
        check_lives(lives_t'(m_lives), d[17:16], "lives");
    endtask

    task automatic verify_key();
        logic [APB_DATA_W-1:0] d;
        apb_read(REG_KEYCODE, d);
        check_word(APB_DATA_W'(m_key), d, "keycode");
    endtask

    task automatic run_leg(input keycode_t key, input int frames, input bit each_score);
        set_key(key);
        for (int i = 0; i < frames; i++) begin
            tick();
            verify_pos();
            if (each_score) verify_score();
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) next_cycle();
        rst = 1'b0;
        model_restart();
        m_key = '0;
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        $display("%-12s %s, %0d errors", name, (errors == err0) ? "ok" : "FAIL", errors - err0);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        int err0;
        err0 = errors;
        verify_pos();
        verify_score();
        verify_key();
        report("reset", err0);
    endtask

    // Serpentine route, carries at 9 to 10 and 99 to 100
    task automatic test_score();
        int                    err0;
        logic [APB_DATA_W-1:0] d;
        err0 = errors;
        run_leg(KEY_D, 9, 1'b1);
        apb_read(REG_SCORE, d);
        check_score(score_bcd_t'(16'h0009), d[15:0], "score at 9");
        run_leg(KEY_D, 17, 1'b1);
        run_leg(KEY_S, 1, 1'b1);
        run_leg(KEY_A, 31, 1'b1);
        run_leg(KEY_S, 1, 1'b1);
        run_leg(KEY_D, 31, 1'b1);
        run_leg(KEY_S, 1, 1'b1);
        run_leg(KEY_A, 9, 1'b1);
        apb_read(REG_SCORE, d);
        check_score(score_bcd_t'(16'h0100), d[15:0], "score at 100");
        run_leg(KEY_D, 2, 1'b1);                    // Back over dug tiles
        report("score", err0);
    endtask

    task automatic test_motion();
        int err0;
        err0 = errors;
        run_leg(KEY_D, GRID_W - START_X + 1, 1'b0);
        run_leg(KEY_W, START_Y + 2, 1'b0);
        run_leg(KEY_A, GRID_W + 1, 1'b0);
        run_leg(KEY_S, GRID_H + 1, 1'b0);
        run_leg(KEY_SPACE, 3, 1'b0);
        run_leg(8'h00, 2, 1'b0);
        verify_score();
        report("motion", err0);
    endtask

    task automatic test_lives();
        int err0;
        err0 = errors;
        send_hit();
        verify_score();
        send_hit();
        verify_score();
        send_hit();                                 // Game over
        verify_score();
        verify_pos();
        run_leg(KEY_D, 2, 1'b1);                    // Tiles dug before score again
        report("lives", err0);
    endtask

    task automatic test_bad_addr();
        int                    err0;
        logic [APB_DATA_W-1:0] d;
        err0 = errors;
        apb_read(4'd2, d);
        check_word('0, d, "prdata at 0x2");
        apb_read(4'd13, d);
        check_word('0, d, "prdata at 0xd");
        apb_write(4'd1, APB_DATA_W'(KEY_W));
        apb_write(4'd5, 32'h1);
        apb_write(4'd15, 32'hffff_ffff);
        verify_key();
        verify_score();
        verify_pos();
        report("bad_addr", err0);
    endtask

    task automatic test_random_walk();
        int       err0;
        int       sel;
        keycode_t key;
        err0 = errors;
        for (int i = 0; i < WALK_FRAMES; i++) begin
            rng = xorshift32(rng);
            sel = int'(rng % 32'd6);
            case (sel)
                0:       key = KEY_W;
                1:       key = KEY_A;
                2:       key = KEY_S;
                3:       key = KEY_D;
                4:       key = KEY_SPACE;
                default: key = 8'h00;
            endcase
            set_key(key);
            tick();
            verify_pos();
            verify_score();
        end
        report("random_walk", err0);
    endtask

    initial begin
        rst        = 1'b1;
        frame_tick = 1'b0;
        apb_req    = '0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        rng        = SEED;
        m_key      = '0;
        apply_reset();
        test_reset();
        test_score();
        apply_reset();
        test_motion();
        test_lives();
        test_bad_addr();
        test_random_walk();
        errors = errors + dut.u_assertions.fails;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut.u_assertions.fails);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
dig_game_pkg.sv
apb_pkg.sv
apb_regs.sv
dug_motion.sv
tunnel_map.sv
score_lives.sv
dig_game_top.sv
dig_game_assertions.sv
tb_dig_game.sv

/* Makefile */
# Verilator build and run for the digger game-state core

VERILATOR ?= verilator
TOP       ?= tb_dig_game
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
